//--- common/neuron_pkg.sv
`default_nettype none

package neuron_pkg;

    // ieee-754 single precision fields
    typedef struct packed {
        logic        sign;                          // 1 -> negative
        logic [7:0]  exponent;                      // biased by 127
        logic [22:0] mantissa;                      // fraction without hidden bit
    } fp_fields_s;

    // one float word seen raw or split into fields
    typedef union packed {
        logic [31:0] raw;                           // whole word for arithmetic paths
        fp_fields_s  f;                             // field view for exponent tricks
    } fp_word_u;

    // neuron model select, code 11 falls back to lif
    typedef enum logic [1:0] {
        MODEL_LIF  = 2'b00,                         // leaky integrate and fire
        MODEL_IZHI = 2'b01,                         // 0.04 v^2 + 5 v
        MODEL_QUAD = 2'b10                          // v^2
    } model_e;

    // lif decay rate, unknown codes divide by 1
    typedef enum logic [3:0] {
        RATE_DIV1         = 4'b0001,                // potential kept
        RATE_DIV2         = 4'b0010,                // exponent - 1
        RATE_DIV4         = 4'b0100,                // exponent - 2
        RATE_DIV8         = 4'b1000,                // exponent - 3
        RATE_HALF_QUARTER = 4'b0011                 // v/2 + v/4
    } decay_rate_e;

    // clock cycles per timestep
    localparam int TIMESTEP_CYCLES = 8;

    // width of the timestep cycle counter
    localparam int TS_CNT_W = $clog2(TIMESTEP_CYCLES);

    // exponent bias and all-ones exponent
    localparam int FP_BIAS    = 127;
    localparam int FP_EXP_MAX = 255;

    // izhikevich coefficients
    localparam logic [31:0] FP_IZHI_A = 32'h3d23d70a;   // 0.04
    localparam logic [31:0] FP_IZHI_B = 32'h40a00000;   // 5.0

endpackage

`default_nettype wire

//--- rtl/fp_add.sv
`timescale 1ns/100ps
`default_nettype none

module fp_add (
    input  wire neuron_pkg::fp_word_u a,            // first operand
    input  wire neuron_pkg::fp_word_u b,            // second operand
    input  wire logic                 sub,          // 1 -> a - b
    output neuron_pkg::fp_word_u      sum           // truncated result
);
    import neuron_pkg::*;

    logic              b_sign;                      // b sign after sub flip
    logic [30:0]       a_mag;                       // magnitudes, denormals flushed
    logic [30:0]       b_mag;
    logic              swap;                        // b has the larger magnitude
    logic [30:0]       big_mag;
    logic [30:0]       small_mag;
    logic              big_sign;
    logic              small_sign;
    logic [7:0]        exp_diff;                    // alignment shift
    logic [48:0]       big_ext;                     // carry, hidden, fraction, 24 ext bits
    logic [48:0]       small_ext;
    logic [48:0]       small_aligned;               // small operand after right shift
    logic              sticky;                      // bits lost during alignment
    logic [48:0]       small_term;
    logic [48:0]       raw_sum;                     // unnormalized magnitude
    logic [5:0]        lz;                          // leading zero count
    logic [48:0]       norm;                        // leading one at bit 48
    logic signed [9:0] exp_res;                     // result exponent before range checks

    assign b_sign = b.f.sign ^ sub;
    assign a_mag  = (a.f.exponent == 8'd0) ? 31'd0 : a.raw[30:0];   // flush denormal a
    assign b_mag  = (b.f.exponent == 8'd0) ? 31'd0 : b.raw[30:0];   // flush denormal b
    assign swap   = (b_mag > a_mag);

    assign big_mag    = swap ? b_mag : a_mag;
    assign small_mag  = swap ? a_mag : b_mag;
    assign big_sign   = swap ? b_sign : a.f.sign;
    assign small_sign = swap ? a.f.sign : b_sign;

    assign exp_diff  = big_mag[30:23] - small_mag[30:23];
    assign big_ext   = {1'b0, |big_mag[30:23], big_mag[22:0], 24'd0};      // hidden bit set if nonzero
    assign small_ext = {1'b0, |small_mag[30:23], small_mag[22:0], 24'd0};

    assign small_aligned = small_ext >> exp_diff;
    assign sticky        = ((small_aligned << exp_diff) != small_ext);   // any bit shifted out
    assign small_term    = small_aligned | {48'd0, sticky};

    // big is never smaller, so the difference stays positive
    assign raw_sum = (big_sign ^ small_sign) ? (big_ext - small_term)
                                             : (big_ext + small_term);

    always_comb begin
        lz = 6'd49;                                 // all zero
        for (int i = 0; i < 49; i++) begin
            if (raw_sum[i]) begin
                lz = 6'(48 - i);                    // highest set bit wins
            end
        end
    end

    assign norm    = raw_sum << lz;
    assign exp_res = $signed({2'b00, big_mag[30:23]}) + 10'sd1 - $signed({4'b0000, lz});

    always_comb begin
        if (raw_sum == 49'd0) begin
            sum.raw = 32'd0;                        // exact cancellation gives +0
        end else if (exp_res <= 0) begin
            sum.f = {big_sign, 8'd0, 23'd0};        // below normal range
        end else if (exp_res >= FP_EXP_MAX) begin
            sum.f = {big_sign, 8'hff, 23'd0};       // saturate to signed infinity
        end else begin
            sum.f = {big_sign, exp_res[7:0], norm[47:25]};   // truncate below lsb
        end
    end

endmodule

`default_nettype wire

//--- rtl/fp_mul.sv
`timescale 1ns/100ps
`default_nettype none

module fp_mul (
    input  wire neuron_pkg::fp_word_u a,            // multiplicand
    input  wire neuron_pkg::fp_word_u b,            // multiplier
    output neuron_pkg::fp_word_u      product       // truncated product
);
    import neuron_pkg::*;

    logic              sign;                        // result sign
    logic              a_zero;                      // zero or denormal input
    logic              b_zero;
    logic              a_inf;                       // all-ones exponent
    logic              b_inf;
    logic [23:0]       a_sig;                       // significands with hidden bit
    logic [23:0]       b_sig;
    logic [47:0]       prod;                        // full 48-bit product
    logic              carry;                       // product in [2,4)
    logic [22:0]       mant;                        // truncated fraction
    logic signed [9:0] exp_res;                     // unbiased sum plus bias

    assign sign   = a.f.sign ^ b.f.sign;
    assign a_zero = (a.f.exponent == 8'd0);
    assign b_zero = (b.f.exponent == 8'd0);
    assign a_inf  = (a.f.exponent == 8'(FP_EXP_MAX));
    assign b_inf  = (b.f.exponent == 8'(FP_EXP_MAX));

    assign a_sig = {1'b1, a.f.mantissa};
    assign b_sig = {1'b1, b.f.mantissa};
    assign prod  = a_sig * b_sig;

    assign carry = prod[47];
    assign mant  = carry ? prod[46:24] : prod[45:23];   // one-position normalize

    assign exp_res = 10'($signed({2'b00, a.f.exponent}) + $signed({2'b00, b.f.exponent})
                         - FP_BIAS + $signed({9'd0, carry}));

    always_comb begin
        if (a_zero || b_zero) begin
            product.f = {sign, 8'd0, 23'd0};        // flushed input gives signed zero
        end else if (a_inf || b_inf) begin
            product.f = {sign, 8'hff, 23'd0};       // infinity propagates
        end else if (exp_res <= 0) begin
            product.f = {sign, 8'd0, 23'd0};        // underflow flush
        end else if (exp_res >= FP_EXP_MAX) begin
            product.f = {sign, 8'hff, 23'd0};       // overflow saturates
        end else begin
            product.f = {sign, exp_res[7:0], mant};
        end
    end

endmodule

`default_nettype wire

//--- rtl/timestep_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module timestep_ctrl (
    input  wire logic CLK_Decay1,                   // core clock
    input  wire logic arst_n,                       // async reset, active low
    input  wire logic load,                         // restarts the timestep
    input  wire logic syn_valid,                    // synaptic strobe, blocks decay
    output logic      decay_en,                     // write next_potential this cycle
    output logic      decay_done                    // new potential visible
);
    import neuron_pkg::*;

    logic [TS_CNT_W-1:0] cycle_cnt;                 // cycles into the current timestep
    logic                pending;                   // decay owed after a collision
    logic                tick;                      // last cycle of the timestep

    assign tick = (cycle_cnt == TS_CNT_W'(TIMESTEP_CYCLES - 1));

    // decay waits for a cycle free of load and synaptic strobes
    assign decay_en = !load && !syn_valid && (tick || pending);

    always_ff @(posedge CLK_Decay1 or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt  <= '0;
            pending    <= 1'b0;
            decay_done <= 1'b0;
        end else begin
            decay_done <= decay_en;                 // one cycle behind the write
            if (load) begin
                cycle_cnt <= '0;                    // restart timestep
                pending   <= 1'b0;                  // drop any deferred decay
            end else begin
                if (tick) begin
                    cycle_cnt <= '0;
                end else begin
                    cycle_cnt <= cycle_cnt + 1'b1;  // keeps running while deferred
                end
                if (decay_en) begin
                    pending <= 1'b0;
                end else if (tick && syn_valid) begin
                    pending <= 1'b1;                // strobe took the tick
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/membrane_store.sv
`timescale 1ns/100ps
`default_nettype none

module membrane_store (
    input  wire logic                 CLK_Decay1,       // core clock
    input  wire logic                 arst_n,           // async reset, active low
    input  wire logic                 load,             // take init_potential
    input  wire neuron_pkg::fp_word_u init_potential,   // starting potential
    input  wire logic                 syn_valid,        // accumulate syn_current
    input  wire neuron_pkg::fp_word_u syn_current,      // synaptic input current
    input  wire logic                 decay_en,         // write back decayed value
    input  wire neuron_pkg::fp_word_u next_potential,   // from potential_decay
    output neuron_pkg::fp_word_u      potential         // stored membrane potential
);
    import neuron_pkg::*;

    fp_word_u acc_sum;                              // potential + syn_current

    fp_add u_acc_add (
        .a   (potential),
        .b   (syn_current),
        .sub (1'b0),                                // currents carry their own sign
        .sum (acc_sum)
    );

    // load wins, then decay, then accumulation
    always_ff @(posedge CLK_Decay1 or negedge arst_n) begin
        if (!arst_n) begin
            potential <= '0;                        // +0.0
        end else if (load) begin
            potential <= init_potential;
        end else if (decay_en) begin
            potential <= next_potential;            // never with syn_valid
        end else if (syn_valid) begin
            potential <= acc_sum;
        end
    end

endmodule

`default_nettype wire

//--- potential_decay/potential_decay.sv
`timescale 1ns/100ps
`default_nettype none

module potential_decay (
    input  wire logic                    CLK_Decay1,    // core clock
    input  wire logic                    arst_n,        // async reset, active low
    input  wire logic                    load,          // latch model and rate
    input  wire neuron_pkg::model_e      model,         // neuron model code
    input  wire neuron_pkg::decay_rate_e decay_rate,    // lif decay code
    input  wire neuron_pkg::fp_word_u    potential,     // current potential
    output neuron_pkg::fp_word_u         next_potential // decayed potential
);
    import neuron_pkg::*;

    model_e      model_q;                           // latched model
    decay_rate_e rate_q;                            // latched decay rate
    fp_word_u    half_v;                            // v / 2
    fp_word_u    quarter_v;                         // v / 4
    fp_word_u    hq_sum;                            // v/2 + v/4
    fp_word_u    lif_result;
    fp_word_u    v_sq;                              // v * v
    fp_word_u    izhi_a_term;                       // 0.04 * v^2
    fp_word_u    izhi_b_term;                       // 5 * v
    fp_word_u    izhi_sum;

    // divide by 2^steps through the exponent field
    function automatic fp_word_u lower_exp(fp_word_u v, logic [1:0] steps);
        fp_word_u r;
        r = v;                                      // infinity passes unchanged
        if (v.f.exponent != 8'(FP_EXP_MAX)) begin
            if (v.f.exponent <= {6'd0, steps}) begin
                r.f.exponent = 8'd0;                // zero or underflow
                r.f.mantissa = 23'd0;
            end else begin
                r.f.exponent = v.f.exponent - {6'd0, steps};
            end
        end
        return r;
    endfunction

    always_ff @(posedge CLK_Decay1 or negedge arst_n) begin
        if (!arst_n) begin
            model_q <= MODEL_LIF;
            rate_q  <= RATE_DIV1;
        end else if (load) begin
            model_q <= model;
            rate_q  <= decay_rate;
        end
    end

    assign half_v    = lower_exp(potential, 2'd1);
    assign quarter_v = lower_exp(potential, 2'd2);

    fp_add u_hq_add   (.a(half_v),      .b(quarter_v),   .sub(1'b0), .sum(hq_sum));
    fp_mul u_vsq_mul  (.a(potential),   .b(potential),   .product(v_sq));
    fp_mul u_izhi_a   (.a(v_sq),        .b(FP_IZHI_A),   .product(izhi_a_term));
    fp_mul u_izhi_b   (.a(potential),   .b(FP_IZHI_B),   .product(izhi_b_term));
    fp_add u_izhi_add (.a(izhi_a_term), .b(izhi_b_term), .sub(1'b0), .sum(izhi_sum));

    always_comb begin
        case (rate_q)
            RATE_DIV2:         lif_result = lower_exp(potential, 2'd1);
            RATE_DIV4:         lif_result = lower_exp(potential, 2'd2);
            RATE_DIV8:         lif_result = lower_exp(potential, 2'd3);
            RATE_HALF_QUARTER: lif_result = hq_sum;                       // 0.75 v
            default:           lif_result = lower_exp(potential, 2'd0);   // divide by 1
        endcase
    end

    always_comb begin
        case (model_q)
            MODEL_IZHI: next_potential = izhi_sum;
            MODEL_QUAD: next_potential = v_sq;
            default:    next_potential = lif_result;   // lif and code 11
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/neuron_core.sv
`timescale 1ns/100ps
`default_nettype none

module neuron_core (
    input  wire logic                    CLK_Decay1,      // core clock
    input  wire logic                    arst_n,          // async reset, active low
    input  wire logic                    load,            // initialize neuron
    input  wire neuron_pkg::fp_word_u    init_potential,  // potential taken on load
    input  wire neuron_pkg::model_e      model,           // model latched on load
    input  wire neuron_pkg::decay_rate_e decay_rate,      // rate latched on load
    input  wire logic                    syn_valid,       // synaptic strobe
    input  wire neuron_pkg::fp_word_u    syn_current,     // synaptic current
    output neuron_pkg::fp_word_u         potential,       // membrane potential
    output logic                         decay_done       // decay result visible
);
    import neuron_pkg::*;

    logic     decay_en;                             // decay write strobe
    fp_word_u next_potential;                       // combinational decay result

    timestep_ctrl u_timestep_ctrl (
        .CLK_Decay1 (CLK_Decay1),
        .arst_n     (arst_n),
        .load       (load),
        .syn_valid  (syn_valid),
        .decay_en   (decay_en),
        .decay_done (decay_done)
    );

    membrane_store u_membrane_store (
        .CLK_Decay1     (CLK_Decay1),
        .arst_n         (arst_n),
        .load           (load),
        .init_potential (init_potential),
        .syn_valid      (syn_valid),
        .syn_current    (syn_current),
        .decay_en       (decay_en),
        .next_potential (next_potential),
        .potential      (potential)
    );

    potential_decay u_potential_decay (
        .CLK_Decay1     (CLK_Decay1),
        .arst_n         (arst_n),
        .load           (load),
        .model          (model),
        .decay_rate     (decay_rate),
        .potential      (potential),
        .next_potential (next_potential)
    );

endmodule

`default_nettype wire

//--- testbench/neuron_core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module neuron_core_asserts (
    input wire logic CLK_Decay1,                    // core clock
    input wire logic arst_n,                        // async reset, active low
    input wire logic load,
    input wire logic syn_valid,
    input wire logic decay_en,
    input wire logic decay_done
);

    int fail_cnt;                                   // assertion failures so far

    // done pulse trails the write strobe by one cycle
    a_done_after_en: assert property (@(posedge CLK_Decay1) disable iff (!arst_n)
        decay_en |=> decay_done)
        else begin
            $error("decay_done missing one cycle after decay_en");
            fail_cnt++;
        end

    a_no_stray_done: assert property (@(posedge CLK_Decay1) disable iff (!arst_n)
        !decay_en |=> !decay_done)
        else begin
            $error("decay_done without a decay_en one cycle before");
            fail_cnt++;
        end

    a_en_not_with_syn: assert property (@(posedge CLK_Decay1) disable iff (!arst_n)
        !(decay_en && syn_valid))
        else begin
            $error("decay_en high together with syn_valid");
            fail_cnt++;
        end

    a_en_not_with_load: assert property (@(posedge CLK_Decay1) disable iff (!arst_n)
        !(decay_en && load))
        else begin
            $error("decay_en high together with load");
            fail_cnt++;
        end

endmodule

bind timestep_ctrl neuron_core_asserts u_neuron_core_asserts (
    .CLK_Decay1 (CLK_Decay1),
    .arst_n     (arst_n),
    .load       (load),
    .syn_valid  (syn_valid),
    .decay_en   (decay_en),
    .decay_done (decay_done)
);

`default_nettype wire

//--- testbench/neuron_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module neuron_core_tb;
    import neuron_pkg::*;

    localparam int         MAX_RECORDS = 64;                    // data file capacity
    localparam string      DATA_FILE   = "testbench/neuron_testdata.txt";
    localparam logic [3:0] OP_IDLE     = 4'h0;                  // operand = idle cycles
    localparam logic [3:0] OP_LOAD     = 4'h1;
    localparam logic [3:0] OP_SYNAPSE  = 4'h2;
    localparam logic [3:0] OP_WAIT     = 4'h3;                  // wait for decay_done
    localparam logic [3:0] OP_END      = 4'hf;                  // end of record list

    logic        CLK_Decay1;
    logic        arst_n;
    logic        load;
    fp_word_u    init_potential;
    model_e      model;
    decay_rate_e decay_rate;
    logic        syn_valid;
    fp_word_u    syn_current;
    fp_word_u    potential;
    logic        decay_done;

    logic [31:0] tdata [0:3*MAX_RECORDS-1];                     // ctrl, operand, expected
    int          num_records;
    int          test_cnt;
    int          check_cnt;
    int          err_cnt;
    int          cycle_cnt;                                     // for the timeout
    int          cycle_limit;                                   // 0 until records are known
    int          sync_cnt;                                      // cycles since load or decay
    logic        deferred;                                      // strobe landed on a tick

    neuron_core u_neuron_core (
        .CLK_Decay1     (CLK_Decay1),
        .arst_n         (arst_n),
        .load           (load),
        .init_potential (init_potential),
        .model          (model),
        .decay_rate     (decay_rate),
        .syn_valid      (syn_valid),
        .syn_current    (syn_current),
        .potential      (potential),
        .decay_done     (decay_done)
    );

    always #10 CLK_Decay1 = ~CLK_Decay1;                        // 20 ns period

    always @(posedge CLK_Decay1) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: decay never completed within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // advance to the next falling edge, where inputs change and outputs are read
    task automatic next_cycle();
        @(negedge CLK_Decay1);
        sync_cnt++;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    function automatic string op_name(input logic [3:0] op);
        case (op)
            OP_LOAD:    return "load";
            OP_SYNAPSE: return "synapse";
            OP_WAIT:    return "decay";
            default:    return "idle";
        endcase
    endfunction

    initial begin
        logic [31:0] ctrl;
        logic [31:0] operand;
        logic [31:0] expected;
        int          errs_before;
        CLK_Decay1          = 1'b0;
        arst_n              = 1'b0;
        load                = 1'b0;
        init_potential.raw  = 32'd0;
        model               = MODEL_LIF;
        decay_rate          = RATE_DIV1;
        syn_valid           = 1'b0;
        syn_current.raw     = 32'd0;
        test_cnt            = 0;
        check_cnt           = 0;
        err_cnt             = 0;
        cycle_cnt           = 0;
        cycle_limit         = 0;
        sync_cnt            = 0;
        deferred            = 1'b0;
        $readmemh(DATA_FILE, tdata);
        num_records = 0;
        while (num_records < MAX_RECORDS) begin                 // stop at end marker
            if ($isunknown(tdata[3*num_records]) || tdata[3*num_records][11:8] == OP_END) begin
                break;
            end
            num_records++;
        end
        if (num_records == 0) begin
            err_cnt++;
            $display("no records could be read from %s", DATA_FILE);
        end
        cycle_limit = (num_records + 4) * TIMESTEP_CYCLES * 2;
        repeat (4) @(negedge CLK_Decay1);
        arst_n   = 1'b1;                                        // release on a falling edge
        sync_cnt = 0;
        check_value("potential", 32'd0, potential.raw);
        check_value("decay_done", 32'd0, {31'd0, decay_done});
        test_cnt++;
        $display("test %0d reset: %s", test_cnt, (err_cnt == 0) ? "ok" : "FAILED");
        for (int i = 0; i < num_records; i++) begin
            ctrl        = tdata[3*i];
            operand     = tdata[3*i+1];
            expected    = tdata[3*i+2];
            errs_before = err_cnt;
            case (ctrl[11:8])
                OP_LOAD: begin
                    load               = 1'b1;
                    init_potential.raw = operand;
                    model              = model_e'(ctrl[5:4]);
                    decay_rate         = decay_rate_e'(ctrl[3:0]);
                    next_cycle();
                    load     = 1'b0;
                    sync_cnt = 0;                               // timestep restarts here
                    deferred = 1'b0;
                    check_value("potential", expected, potential.raw);
                end
                OP_SYNAPSE: begin
                    if (sync_cnt == TIMESTEP_CYCLES - 1) begin
                        deferred = 1'b1;                        // strobe takes the tick cycle
                    end
                    syn_valid       = 1'b1;
                    syn_current.raw = operand;
                    next_cycle();
                    syn_valid = 1'b0;
                    check_value("potential", expected, potential.raw);
                end
                OP_WAIT: begin
                    next_cycle();
                    while (!decay_done) begin
                        next_cycle();
                    end
                    // a deferred decay lands one cycle late
                    check_value("decay_latency", 32'(TIMESTEP_CYCLES + int'(deferred)),
                                32'(sync_cnt));
                    check_value("potential", expected, potential.raw);
                    sync_cnt = 0;
                    deferred = 1'b0;
                end
                default: begin
                    repeat (operand) next_cycle();
                end
            endcase
            if (ctrl[11:8] != OP_IDLE) begin
                test_cnt++;
                $display("test %0d %s: %s", test_cnt, op_name(ctrl[11:8]),
                         (err_cnt == errs_before) ? "ok" : "FAILED");
            end
        end
        // failed concurrent assertions in the bound checker
        err_cnt = err_cnt + u_neuron_core.u_timestep_ctrl.u_neuron_core_asserts.fail_cnt;
        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/neuron_testdata.txt
// ctrl = op model rate (op 0 idle, 1 load, 2 synapse, 3 wait for decay, f end)
// columns: ctrl operand expected_potential (idle operand = cycle count)
300 00000000 00000000
102 42806b85 42806b85
300 00000000 42006b85
300 00000000 41806b85
104 40400000 40400000
300 00000000 3f400000
108 41000000 41000000
300 00000000 3f800000
101 c0a00000 c0a00000
300 00000000 c0a00000
103 3f800001 3f800001
300 00000000 3f400001
102 3f800000 3f800000
200 40000000 40400000
200 bf800000 40000000
200 c0400000 bf800000
300 00000000 bf000000
102 40000000 40000000
000 00000007 00000000
200 3f800000 40400000
300 00000000 3fc00000
111 41200000 41200000
300 00000000 4257ffff
121 40400000 40400000
300 00000000 41100000
300 00000000 42a20000
121 df800000 df800000
300 00000000 7f800000
f00 00000000 00000000

//--- flist.f
common/neuron_pkg.sv
rtl/fp_add.sv
rtl/fp_mul.sv
rtl/timestep_ctrl.sv
rtl/membrane_store.sv
potential_decay/potential_decay.sv
rtl/neuron_core.sv
testbench/neuron_core_asserts.sv
testbench/neuron_core_tb.sv
